// File: execCore.f
src/aluPkg.sv
src/aluOpIf.sv
src/opQueue.sv
src/arithLogicUnit.sv
src/mulUnit.sv
src/divUnit.sv
src/intAlu.sv
src/execCore.sv
testbench/tb_execCore.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f execCore.f --top-module tb_execCore -o tb_execCore; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_execCore > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi

cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi

exit 0

// File: src/aluOpIf.sv
`timescale 1ns/1ps

interface aluOpIf
	import aluPkg::*;
();

	// Head entry of the input queue
	logic            valid;
	logic [XLEN-1:0] rs1;
	logic [XLEN-1:0] rs2;
	aluUnitE         unit;
	logic [2:0]      funct3;
	logic            funct75;

	// Head consumed at this clock edge
	logic            pop;

	modport queue (
		output valid,
		output rs1,
		output rs2,
		output unit,
		output funct3,
		output funct75,
		input  pop
	);

	modport alu (
		input  valid,
		input  rs1,
		input  rs2,
		input  unit,
		input  funct3,
		input  funct75,
		output pop
	);

endinterface

// File: src/aluPkg.sv
package aluPkg;

	// Datapath widths
	localparam int XLEN = 32;
	localparam int SHAMT_W = 5;
	localparam int DIV_CNT_W = $clog2(XLEN + 1);

	// Source side holds one credit per queue entry
	localparam int OP_QUEUE_DEPTH = 2;
	localparam int OPQ_PTR_W = (OP_QUEUE_DEPTH > 1) ? $clog2(OP_QUEUE_DEPTH) : 1;
	localparam int OPQ_CNT_W = $clog2(OP_QUEUE_DEPTH + 1);

	// Credits toward the result consumer
	localparam int RESULT_CREDITS = 2;
	localparam int RES_CRED_W = $clog2(RESULT_CREDITS + 1);

	typedef enum logic [2:0] {
		UNIT_ADDSUB = 3'd0,
		UNIT_MUL    = 3'd1,
		UNIT_DIV    = 3'd2,
		UNIT_SET    = 3'd3,
		UNIT_LOGIC  = 3'd4,
		UNIT_SHIFT  = 3'd5,
		UNIT_BRANCH = 3'd6
	} aluUnitE;

	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0,
		DIV_RUN  = 2'd1,
		DIV_DONE = 2'd2
	} divStateE;

	// RISC-V funct3 encodings
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;
	localparam logic [2:0] F3_SLL    = 3'b001;
	localparam logic [2:0] F3_SR     = 3'b101;
	localparam logic [2:0] F3_SLT    = 3'b010;
	localparam logic [2:0] F3_SLTU   = 3'b011;
	localparam logic [2:0] F3_MUL    = 3'b000;
	localparam logic [2:0] F3_MULH   = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU  = 3'b011;
	localparam logic [2:0] F3_DIV    = 3'b100;
	localparam logic [2:0] F3_DIVU   = 3'b101;
	localparam logic [2:0] F3_REM    = 3'b110;
	localparam logic [2:0] F3_REMU   = 3'b111;
	localparam logic [2:0] F3_BEQ    = 3'b000;
	localparam logic [2:0] F3_BNE    = 3'b001;
	localparam logic [2:0] F3_BLT    = 3'b100;
	localparam logic [2:0] F3_BGE    = 3'b101;
	localparam logic [2:0] F3_BLTU   = 3'b110;
	localparam logic [2:0] F3_BGEU   = 3'b111;

endpackage

// File: src/arithLogicUnit.sv
`timescale 1ns/1ps

module arithLogicUnit
	import aluPkg::*;
(
	input  logic [XLEN-1:0] rs1,
	input  logic [XLEN-1:0] rs2,
	input  aluUnitE         unit,
	input  logic [2:0]      funct3,
	input  logic            funct75,
	output logic [XLEN-1:0] result,
	output logic            overflow,
	output logic            branchTaken
);

	logic [XLEN-1:0]    addend;
	logic [XLEN-1:0]    sum;
	logic [XLEN-1:0]    setRes;
	logic [XLEN-1:0]    logicRes;
	logic [XLEN-1:0]    shiftRes;
	logic [SHAMT_W-1:0] shamt;
	logic               ltSigned;
	logic               ltUnsigned;
	logic               cmpTaken;

	// Subtract as rs1 + ~rs2 + 1
	assign addend = funct75 ? ~rs2 : rs2;
	assign sum    = rs1 + addend + XLEN'(funct75);

	assign ltSigned   = $signed(rs1) < $signed(rs2);
	assign ltUnsigned = rs1 < rs2;
	assign shamt      = rs2[SHAMT_W-1:0];

	always_comb begin
		setRes = '0;
		case (funct3)
			F3_SLT:  setRes[0] = ltSigned;
			F3_SLTU: setRes[0] = ltUnsigned;
			default: setRes = '0;
		endcase
	end

	always_comb begin
		case (funct3)
			F3_XOR:  logicRes = rs1 ^ rs2;
			F3_OR:   logicRes = rs1 | rs2;
			F3_AND:  logicRes = rs1 & rs2;
			default: logicRes = '0;
		endcase
	end

	always_comb begin
		shiftRes = '0;
		if (funct3 == F3_SLL)
			shiftRes = rs1 << shamt;
		else if (funct3 == F3_SR) begin
			// SRA copies the sign bit in
			if (funct75)
				shiftRes = $signed(rs1) >>> shamt;
			else
				shiftRes = rs1 >> shamt;
		end
	end

	always_comb begin
		case (funct3)
			F3_BEQ:  cmpTaken = (rs1 == rs2);
			F3_BNE:  cmpTaken = (rs1 != rs2);
			F3_BLT:  cmpTaken = ltSigned;
			F3_BGE:  cmpTaken = !ltSigned;
			F3_BLTU: cmpTaken = ltUnsigned;
			F3_BGEU: cmpTaken = !ltUnsigned;
			default: cmpTaken = 1'b0;
		endcase
	end

	// Branches return only the taken flag
	always_comb begin
		case (unit)
			UNIT_ADDSUB: result = sum;
			UNIT_SET:    result = setRes;
			UNIT_LOGIC:  result = logicRes;
			UNIT_SHIFT:  result = shiftRes;
			default:     result = '0;
		endcase
	end

	// Same-sign inputs giving a different-sign sum
	assign overflow = (unit == UNIT_ADDSUB) && (rs1[XLEN-1] == addend[XLEN-1])
		&& (sum[XLEN-1] != rs1[XLEN-1]);
	assign branchTaken = (unit == UNIT_BRANCH) && cmpTaken;

endmodule

// File: src/divUnit.sv
`timescale 1ns/1ps

module divUnit
	import aluPkg::*;
(
	input  logic            CLK,
	input  logic            rst_n,
	input  logic            start,
	input  logic [XLEN-1:0] dividend,
	input  logic [XLEN-1:0] divisor,
	input  logic [2:0]      funct3,
	output logic [XLEN-1:0] quotRem,
	output logic            divByZero,
	output logic            done
);

	divStateE             state;
	logic [DIV_CNT_W-1:0] iterCnt;
	logic [XLEN-1:0]      quo;
	logic [XLEN-1:0]      rem;
	logic [XLEN-1:0]      divisorMag;
	logic                 negQuo;
	logic                 negRem;
	logic                 remSel;
	logic                 signedOp;
	logic                 remOp;
	logic                 dividendNeg;
	logic                 divisorNeg;
	logic [XLEN:0]        shifted;
	logic [XLEN+1:0]      trial;
	logic [XLEN-1:0]      quoFixed;
	logic [XLEN-1:0]      remFixed;

	always_comb begin
		case (funct3)
			F3_DIV:  {signedOp, remOp} = 2'b10;
			F3_DIVU: {signedOp, remOp} = 2'b00;
			F3_REM:  {signedOp, remOp} = 2'b11;
			F3_REMU: {signedOp, remOp} = 2'b01;
			default: {signedOp, remOp} = 2'b00;
		endcase
	end

	assign dividendNeg = signedOp & dividend[XLEN-1];
	assign divisorNeg  = signedOp & divisor[XLEN-1];

	// One restoring step
	assign shifted = {rem, quo[XLEN-1]};
	assign trial   = {1'b0, shifted} - {2'b0, divisorMag};

	// Remainder takes the dividend's sign
	assign quoFixed = negQuo ? -quo : quo;
	assign remFixed = negRem ? -rem : rem;

	assign done = (state == DIV_DONE);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state   <= DIV_IDLE;
			iterCnt <= '0;
		end else begin
			case (state)
				DIV_IDLE: begin
					iterCnt <= '0;
					if (start && divisor == '0)
						state <= DIV_DONE;
					else if (start)
						state <= DIV_RUN;
				end
				DIV_RUN: begin
					if (iterCnt == DIV_CNT_W'(XLEN))
						state <= DIV_DONE;
					else
						iterCnt <= iterCnt + 1'b1;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == DIV_IDLE && start) begin
			remSel     <= remOp;
			negQuo     <= dividendNeg ^ divisorNeg;
			negRem     <= dividendNeg;
			quo        <= dividendNeg ? -dividend : dividend;
			divisorMag <= divisorNeg ? -divisor : divisor;
			rem        <= '0;
			divByZero  <= (divisor == '0);
			// Zero divisor result per the RISC-V spec
			if (divisor == '0)
				quotRem <= remOp ? dividend : '1;
		end else if (state == DIV_RUN) begin
			if (iterCnt == DIV_CNT_W'(XLEN))
				quotRem <= remSel ? remFixed : quoFixed;
			else begin
				quo <= {quo[XLEN-2:0], ~trial[XLEN+1]};
				rem <= trial[XLEN+1] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
			end
		end
	end

endmodule

// File: src/execCore.sv
`timescale 1ns/1ps

module execCore
	import aluPkg::*;
(
	input  logic            CLK,
	input  logic            rst_n,

	// Source side
	input  logic            opValid,
	input  logic [XLEN-1:0] opRs1,
	input  logic [XLEN-1:0] opRs2,
	input  aluUnitE         opUnit,
	input  logic [2:0]      opFunct3,
	input  logic            opFunct75,
	output logic            opCredit,

	// Consumer side
	output logic            resValid,
	output logic [XLEN-1:0] resData,
	output logic            resBranchTaken,
	output logic            resOverflow,
	output logic            resDivByZero,
	input  logic            resCredit
);

	aluOpIf opBus ();

	opQueue u_queue (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.opValid  (opValid),
		.opRs1    (opRs1),
		.opRs2    (opRs2),
		.opUnit   (opUnit),
		.opFunct3 (opFunct3),
		.opFunct75(opFunct75),
		.opCredit (opCredit),
		.head     (opBus)
	);

	intAlu u_intAlu (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.op            (opBus),
		.resCredit     (resCredit),
		.resValid      (resValid),
		.resData       (resData),
		.resBranchTaken(resBranchTaken),
		.resOverflow   (resOverflow),
		.resDivByZero  (resDivByZero)
	);

endmodule

// File: src/intAlu.sv
`timescale 1ns/1ps

module intAlu
	import aluPkg::*;
(
	input  logic            CLK,
	input  logic            rst_n,
	aluOpIf.alu             op,
	input  logic            resCredit,
	output logic            resValid,
	output logic [XLEN-1:0] resData,
	output logic            resBranchTaken,
	output logic            resOverflow,
	output logic            resDivByZero
);

	logic [XLEN-1:0]       aluResult;
	logic [XLEN-1:0]       product;
	logic [XLEN-1:0]       quotRem;
	logic [XLEN-1:0]       resReg;
	logic                  aluOverflow;
	logic                  aluBranch;
	logic                  isDiv;
	logic                  divStart;
	logic                  divDone;
	logic                  divByZero;
	logic                  divBusy;
	logic                  aluValid;
	logic                  ovfReg;
	logic                  branchReg;
	logic [RES_CRED_W-1:0] creditCnt;

	arithLogicUnit u_alu (
		.rs1        (op.rs1),
		.rs2        (op.rs2),
		.unit       (op.unit),
		.funct3     (op.funct3),
		.funct75    (op.funct75),
		.result     (aluResult),
		.overflow   (aluOverflow),
		.branchTaken(aluBranch)
	);

	mulUnit u_mul (
		.rs1    (op.rs1),
		.rs2    (op.rs2),
		.funct3 (op.funct3),
		.product(product)
	);

	divUnit u_div (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.start    (divStart),
		.dividend (op.rs1),
		.divisor  (op.rs2),
		.funct3   (op.funct3),
		.quotRem  (quotRem),
		.divByZero(divByZero),
		.done     (divDone)
	);

	assign isDiv = (op.unit == UNIT_DIV);

	// A result leaving this cycle has already used its credit
	assign op.pop   = op.valid && !divBusy && (creditCnt > RES_CRED_W'(resValid));
	assign divStart = op.pop && isDiv;

	// Divider output never overlaps a single-cycle result
	assign resValid       = aluValid || divDone;
	assign resData        = divDone ? quotRem : resReg;
	assign resBranchTaken = aluValid && branchReg;
	assign resOverflow    = aluValid && ovfReg;
	assign resDivByZero   = divDone && divByZero;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			aluValid  <= 1'b0;
			divBusy   <= 1'b0;
			creditCnt <= RES_CRED_W'(RESULT_CREDITS);
		end else begin
			aluValid <= op.pop && !isDiv;
			if (divStart)
				divBusy <= 1'b1;
			else if (divDone)
				divBusy <= 1'b0;
			creditCnt <= creditCnt + RES_CRED_W'(resCredit) - RES_CRED_W'(resValid);
		end
	end

	always_ff @(posedge CLK) begin
		if (op.pop && !isDiv) begin
			resReg    <= (op.unit == UNIT_MUL) ? product : aluResult;
			ovfReg    <= aluOverflow;
			branchReg <= aluBranch;
		end
	end

endmodule

// File: src/mulUnit.sv
`timescale 1ns/1ps

module mulUnit
	import aluPkg::*;
(
	input  logic [XLEN-1:0] rs1,
	input  logic [XLEN-1:0] rs2,
	input  logic [2:0]      funct3,
	output logic [XLEN-1:0] product
);

	logic                     signA;
	logic                     signB;
	logic signed [XLEN:0]     opA;
	logic signed [XLEN:0]     opB;
	logic signed [2*XLEN+1:0] fullProd;

	always_comb begin
		case (funct3)
			F3_MULH:   {signA, signB} = 2'b11;
			F3_MULHSU: {signA, signB} = 2'b10;
			default:   {signA, signB} = 2'b00;
		endcase
	end

	// One extra bit makes every variant a signed multiply
	assign opA      = {signA & rs1[XLEN-1], rs1};
	assign opB      = {signB & rs2[XLEN-1], rs2};
	assign fullProd = opA * opB;

	always_comb begin
		case (funct3)
			F3_MULH, F3_MULHSU, F3_MULHU: product = fullProd[2*XLEN-1:XLEN];
			default:                      product = fullProd[XLEN-1:0];
		endcase
	end

endmodule

// File: src/opQueue.sv
`timescale 1ns/1ps

module opQueue
	import aluPkg::*;
(
	input  logic            CLK,
	input  logic            rst_n,
	input  logic            opValid,
	input  logic [XLEN-1:0] opRs1,
	input  logic [XLEN-1:0] opRs2,
	input  aluUnitE         opUnit,
	input  logic [2:0]      opFunct3,
	input  logic            opFunct75,
	output logic            opCredit,
	aluOpIf.queue           head
);

	logic [XLEN-1:0]      rs1Mem [OP_QUEUE_DEPTH];
	logic [XLEN-1:0]      rs2Mem [OP_QUEUE_DEPTH];
	aluUnitE              unitMem [OP_QUEUE_DEPTH];
	logic [2:0]           funct3Mem [OP_QUEUE_DEPTH];
	logic                 funct75Mem [OP_QUEUE_DEPTH];
	logic [OPQ_PTR_W-1:0] wrPtr;
	logic [OPQ_PTR_W-1:0] rdPtr;
	logic [OPQ_CNT_W-1:0] count;

	function automatic logic [OPQ_PTR_W-1:0] nextPtr(input logic [OPQ_PTR_W-1:0] ptr);
		return (ptr == OPQ_PTR_W'(OP_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Source credits guarantee a free slot
	always_ff @(posedge CLK) begin
		if (opValid) begin
			rs1Mem[wrPtr]     <= opRs1;
			rs2Mem[wrPtr]     <= opRs2;
			unitMem[wrPtr]    <= opUnit;
			funct3Mem[wrPtr]  <= opFunct3;
			funct75Mem[wrPtr] <= opFunct75;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (opValid)
				wrPtr <= nextPtr(wrPtr);
			if (head.pop)
				rdPtr <= nextPtr(rdPtr);
			case ({opValid, head.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head.valid   = (count != '0);
	assign head.rs1     = rs1Mem[rdPtr];
	assign head.rs2     = rs2Mem[rdPtr];
	assign head.unit    = unitMem[rdPtr];
	assign head.funct3  = funct3Mem[rdPtr];
	assign head.funct75 = funct75Mem[rdPtr];

	// Slot frees up in the pop cycle
	assign opCredit = head.pop;

endmodule

// File: testbench/tb_execCore.sv
`timescale 1ns/1ps

module tb_execCore
	import aluPkg::*;
();

	logic            CLK;
	logic            rst_n;
	logic            opValid;
	logic [XLEN-1:0] opRs1;
	logic [XLEN-1:0] opRs2;
	aluUnitE         opUnit;
	logic [2:0]      opFunct3;
	logic            opFunct75;
	logic            opCredit;
	logic            resValid;
	logic [XLEN-1:0] resData;
	logic            resBranchTaken;
	logic            resOverflow;
	logic            resDivByZero;
	logic            resCredit;

	int seed = 28;
	int cycle;
	int valueErrs;
	int otherErrs;
	int srcCredits;
	int stageCredits;
	int creditDelay;
	int resCount;
	int lastLatency;
	logic holdCredits;

	// Expected {divByZero, overflow, taken, data} in issue order
	logic [XLEN+2:0] expQ[$];
	int              expCycle[$];
	int              creditDue[$];
	logic [XLEN+2:0] expRes;

	execCore u_dut (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.opValid       (opValid),
		.opRs1         (opRs1),
		.opRs2         (opRs2),
		.opUnit        (opUnit),
		.opFunct3      (opFunct3),
		.opFunct75     (opFunct75),
		.opCredit      (opCredit),
		.resValid      (resValid),
		.resData       (resData),
		.resBranchTaken(resBranchTaken),
		.resOverflow   (resOverflow),
		.resDivByZero  (resDivByZero),
		.resCredit     (resCredit)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK)
		cycle <= cycle + 1;

	task automatic checkVal(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] expected);
		if (got !== expected) begin
			valueErrs++;
			$display("ERR %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic reportFail(input string msg);
		otherErrs++;
		$display("%s (cycle %0d)", msg, cycle);
	endtask

	function automatic logic [XLEN-1:0] divRef(input logic [2:0] f3,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic signed [XLEN-1:0] sa;
		logic signed [XLEN-1:0] sb;
		logic                   ovfCase;
		sa = a;
		sb = b;
		ovfCase = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
		if (b == '0)
			return (f3 == F3_DIV || f3 == F3_DIVU) ? '1 : a;
		// Signed overflow gives the dividend back with a zero remainder
		if (ovfCase && f3 == F3_DIV)
			return a;
		if (ovfCase && f3 == F3_REM)
			return '0;
		case (f3)
			F3_DIV:  return sa / sb;
			F3_REM:  return sa % sb;
			F3_DIVU: return a / b;
			default: return a % b;
		endcase
	endfunction

	function automatic logic [XLEN+2:0] refModel(input aluUnitE unit, input logic [2:0] f3,
		input logic f75, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0]   d;
		logic [2*XLEN-1:0] ea;
		logic [2*XLEN-1:0] eb;
		logic [2*XLEN-1:0] p;
		logic              tk;
		logic              ov;
		logic              dz;
		d  = '0;
		tk = 1'b0;
		ov = 1'b0;
		dz = 1'b0;
		case (unit)
			UNIT_ADDSUB: begin
				d  = f75 ? a - b : a + b;
				ov = ((a[XLEN-1] ^ b[XLEN-1]) == f75) && (d[XLEN-1] != a[XLEN-1]);
			end
			UNIT_SET:
				d = (f3 == F3_SLT) ? XLEN'($signed(a) < $signed(b)) : XLEN'(a < b);
			UNIT_LOGIC:
				d = (f3 == F3_XOR) ? a ^ b : (f3 == F3_OR) ? a | b : a & b;
			UNIT_SHIFT: begin
				if (f3 == F3_SLL)
					d = a << b[SHAMT_W-1:0];
				else if (f75)
					d = $signed(a) >>> b[SHAMT_W-1:0];
				else
					d = a >> b[SHAMT_W-1:0];
			end
			UNIT_MUL: begin
				// Low 64 bits of the extended product are exact for every sign mix
				ea = (f3 == F3_MULH || f3 == F3_MULHSU) ? {{XLEN{a[XLEN-1]}}, a}
					: {{XLEN{1'b0}}, a};
				eb = (f3 == F3_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
				p  = ea * eb;
				d  = (f3 == F3_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
			end
			UNIT_DIV: begin
				d  = divRef(f3, a, b);
				dz = (b == '0);
			end
			UNIT_BRANCH: begin
				case (f3)
					F3_BEQ:  tk = (a == b);
					F3_BNE:  tk = (a != b);
					F3_BLT:  tk = $signed(a) < $signed(b);
					F3_BGE:  tk = $signed(a) >= $signed(b);
					F3_BLTU: tk = a < b;
					default: tk = a >= b;
				endcase
			end
			default: d = '0;
		endcase
		return {dz, ov, tk, d};
	endfunction

	// Consumer side monitor
	always @(negedge CLK) begin
		if (rst_n) begin
			if (opCredit)
				srcCredits++;
			if (resValid) begin
				if (stageCredits == 0)
					reportFail("Result sent while the consumer held no credit");
				stageCredits--;
				resCount++;
				creditDue.push_back(cycle + creditDelay);
				if (expQ.size() == 0) begin
					reportFail("Result arrived with no operation outstanding");
				end else begin
					expRes = expQ.pop_front();
					lastLatency = cycle - expCycle.pop_front();
					checkVal("resData", resData, expRes[XLEN-1:0]);
					checkVal("resBranchTaken", XLEN'(resBranchTaken), XLEN'(expRes[XLEN]));
					checkVal("resOverflow", XLEN'(resOverflow), XLEN'(expRes[XLEN+1]));
					checkVal("resDivByZero", XLEN'(resDivByZero), XLEN'(expRes[XLEN+2]));
				end
			end
			if (resCredit)
				stageCredits++;
		end
	end

	// Credits go back creditDelay cycles after each result
	always @(posedge CLK) begin
		#1;
		if (rst_n && !holdCredits && creditDue.size() > 0 && creditDue[0] <= cycle) begin
			resCredit = 1'b1;
			void'(creditDue.pop_front());
		end else begin
			resCredit = 1'b0;
		end
	end

	task automatic sendOp(input aluUnitE unit, input logic [2:0] f3, input logic f75,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		int n;
		n = 0;
		while (srcCredits == 0 && n < 200) begin
			@(posedge CLK);
			#1;
			n++;
		end
		if (srcCredits == 0)
			reportFail("Timed out waiting for a source credit");
		opValid   = 1'b1;
		opUnit    = unit;
		opFunct3  = f3;
		opFunct75 = f75;
		opRs1     = a;
		opRs2     = b;
		srcCredits--;
		expQ.push_back(refModel(unit, f3, f75, a, b));
		expCycle.push_back(cycle);
		@(posedge CLK);
		#1;
		opValid = 1'b0;
	endtask

	task automatic waitResults(input int target);
		int n;
		n = 0;
		while (resCount < target && n < 200) begin
			@(posedge CLK);
			#1;
			n++;
		end
		if (resCount < target)
			reportFail("Timed out waiting for a result");
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while ((expQ.size() != 0 || srcCredits != OP_QUEUE_DEPTH
			|| stageCredits != RESULT_CREDITS) && n < 400) begin
			@(posedge CLK);
			#1;
			n++;
		end
		if (expQ.size() != 0 || srcCredits != OP_QUEUE_DEPTH
			|| stageCredits != RESULT_CREDITS)
			reportFail("Timed out waiting for the pipeline to drain");
	endtask

	task automatic isolatedOp(input aluUnitE unit, input logic [2:0] f3, input logic f75,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input int lat);
		int target;
		waitIdle();
		target = resCount + 1;
		sendOp(unit, f3, f75, a, b);
		waitResults(target);
		checkVal("resValid latency", XLEN'(lastLatency), XLEN'(lat));
	endtask

	task automatic addSubTest();
		sendOp(UNIT_ADDSUB, 3'b000, 1'b0, 32'd5, 32'd7);
		sendOp(UNIT_ADDSUB, 3'b000, 1'b1, 32'd5, 32'd7);
		// Positive then negative overflow
		sendOp(UNIT_ADDSUB, 3'b000, 1'b0, 32'h7fff_ffff, 32'd1);
		sendOp(UNIT_ADDSUB, 3'b000, 1'b1, 32'h8000_0000, 32'd1);
		sendOp(UNIT_ADDSUB, 3'b000, 1'b0, 32'h8000_0000, 32'h8000_0000);
		sendOp(UNIT_ADDSUB, 3'b000, 1'b1, 32'h7fff_ffff, 32'hffff_ffff);
		for (int i = 0; i < 6; i++)
			sendOp(UNIT_ADDSUB, 3'b000, i[0], $random(seed), $random(seed));
		waitIdle();
	endtask

	task automatic setLogicShiftTest();
		sendOp(UNIT_SET, F3_SLT, 1'b0, 32'hffff_ffff, 32'd1);
		sendOp(UNIT_SET, F3_SLTU, 1'b0, 32'hffff_ffff, 32'd1);
		sendOp(UNIT_SET, F3_SLT, 1'b0, 32'd4, 32'd4);
		sendOp(UNIT_SET, F3_SLTU, 1'b0, 32'd3, 32'd9);
		for (int i = 0; i < 3; i++) begin
			sendOp(UNIT_LOGIC, F3_XOR, 1'b0, $random(seed), $random(seed));
			sendOp(UNIT_LOGIC, F3_OR, 1'b0, $random(seed), $random(seed));
			sendOp(UNIT_LOGIC, F3_AND, 1'b0, $random(seed), $random(seed));
		end
		sendOp(UNIT_SHIFT, F3_SLL, 1'b0, 32'h8765_4321, 32'd0);
		sendOp(UNIT_SHIFT, F3_SLL, 1'b0, 32'h8765_4321, 32'd31);
		sendOp(UNIT_SHIFT, F3_SR, 1'b0, 32'h8765_4321, 32'd31);
		sendOp(UNIT_SHIFT, F3_SR, 1'b1, 32'h8765_4321, 32'd4);
		sendOp(UNIT_SHIFT, F3_SR, 1'b1, 32'h8765_4321, 32'd31);
		sendOp(UNIT_SHIFT, F3_SR, 1'b1, 32'h8765_4321, 32'd0);
		// Upper bits of rs2 are ignored
		sendOp(UNIT_SHIFT, F3_SLL, 1'b0, 32'h0000_00ff, 32'hffff_ffe5);
		waitIdle();
	endtask

	task automatic mulTest();
		logic [2:0]      mulOps[4] = '{F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU};
		logic [XLEN-1:0] lhs[4] = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		logic [XLEN-1:0] rhs[4] = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000};
		for (int v = 0; v < 4; v++) begin
			for (int k = 0; k < 4; k++)
				isolatedOp(UNIT_MUL, mulOps[v], 1'b0, lhs[k], rhs[k], 2);
			for (int k = 0; k < 3; k++)
				isolatedOp(UNIT_MUL, mulOps[v], 1'b0, $random(seed), $random(seed), 2);
		end
	endtask

	task automatic divTest();
		logic [2:0]      divOps[4] = '{F3_DIV, F3_DIVU, F3_REM, F3_REMU};
		logic [XLEN-1:0] b;
		for (int v = 0; v < 4; v++) begin
			for (int k = 0; k < 3; k++) begin
				b = $random(seed);
				isolatedOp(UNIT_DIV, divOps[v], 1'b0, $random(seed), b, (b == '0) ? 2 : XLEN + 3);
			end
			isolatedOp(UNIT_DIV, divOps[v], 1'b0, 32'hffff_fff9, 32'd2, XLEN + 3);
			isolatedOp(UNIT_DIV, divOps[v], 1'b0, 32'h1234_5678, 32'd0, 2);
			isolatedOp(UNIT_DIV, divOps[v], 1'b0, 32'h8000_0000, 32'hffff_ffff, XLEN + 3);
		end
	endtask

	task automatic branchTest();
		logic [2:0]      brOps[6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		logic [XLEN-1:0] lhs[5] = '{32'd5, 32'd3, 32'd9, 32'hffff_ffff, 32'd1};
		logic [XLEN-1:0] rhs[5] = '{32'd5, 32'd9, 32'd3, 32'd1, 32'hffff_ffff};
		for (int v = 0; v < 6; v++)
			for (int k = 0; k < 5; k++)
				sendOp(UNIT_BRANCH, brOps[v], 1'b0, lhs[k], rhs[k]);
		waitIdle();
	endtask

	task automatic backPressureTest();
		int holdStart;
		waitIdle();
		holdCredits = 1'b1;
		holdStart = resCount;
		sendOp(UNIT_ADDSUB, 3'b000, 1'b0, 32'd100, 32'd23);
		sendOp(UNIT_DIV, F3_DIV, 1'b0, 32'hffff_ff00, 32'd7);
		sendOp(UNIT_MUL, F3_MULH, 1'b0, $random(seed), $random(seed));
		sendOp(UNIT_LOGIC, F3_XOR, 1'b0, $random(seed), $random(seed));
		waitResults(holdStart + RESULT_CREDITS);
		// Nothing more may leave while credits are withheld
		repeat (20) @(posedge CLK);
		#1;
		checkVal("results under back-pressure", XLEN'(resCount - holdStart),
			XLEN'(RESULT_CREDITS));
		checkVal("source credits", XLEN'(srcCredits), '0);
		holdCredits = 1'b0;
		sendOp(UNIT_SET, F3_SLTU, 1'b0, 32'd1, 32'hffff_fffe);
		sendOp(UNIT_DIV, F3_REM, 1'b0, 32'hffff_ff00, 32'd7);
		sendOp(UNIT_BRANCH, F3_BGE, 1'b0, 32'hffff_fff0, 32'd2);
		sendOp(UNIT_ADDSUB, 3'b000, 1'b1, 32'h8000_0000, 32'd5);
		waitIdle();
	endtask

	initial begin
		CLK          = 1'b0;
		rst_n        = 1'b0;
		opValid      = 1'b0;
		opRs1        = '0;
		opRs2        = '0;
		opUnit       = UNIT_ADDSUB;
		opFunct3     = '0;
		opFunct75    = 1'b0;
		resCredit    = 1'b0;
		cycle        = 0;
		valueErrs    = 0;
		otherErrs    = 0;
		srcCredits   = OP_QUEUE_DEPTH;
		stageCredits = RESULT_CREDITS;
		creditDelay  = 3;
		resCount     = 0;
		lastLatency  = 0;
		holdCredits  = 1'b0;
		repeat (8) @(posedge CLK);
		#1;
		rst_n = 1'b1;

		addSubTest();
		setLogicShiftTest();
		mulTest();
		divTest();
		branchTest();
		backPressureTest();

		$display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
		if (valueErrs == 0 && otherErrs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
